/* rtl/ram_pkg.sv */
// Shared sizes, timing constants, grant source and sequencer state enums
`default_nettype none

package ram_pkg;

    // Word address split into row and column halves
    localparam int ADDR_W = 10;
    localparam int ROW_W  = 5;  // Upper address bits
    localparam int COL_W  = 5;  // Lower address bits

    // 16-bit word, low lane 7:0, high lane 15:8
    localparam int DATA_W = 16;
    localparam int LANE_W = DATA_W / 2;

    // Cycles between refresh requests
    localparam int REFRESH_INTERVAL = 64;
    localparam int REF_CNT_W        = $clog2(REFRESH_INTERVAL);
    localparam logic [REF_CNT_W-1:0] REF_LAST = REF_CNT_W'(REFRESH_INTERVAL - 1);

    // Bus write data wait before giving up
    localparam int BUS_WAIT_LIMIT = 6;
    localparam int WAIT_CNT_W     = $clog2(BUS_WAIT_LIMIT);
    localparam logic [WAIT_CNT_W-1:0] WAIT_LAST = WAIT_CNT_W'(BUS_WAIT_LIMIT - 1);

    // Who owns the current RAM cycle
    typedef enum logic [1:0] {
        SRC_CPU,
        SRC_BUS,
        SRC_REFRESH
    } src_t;

    // Sequencer states, access path then CAS-before-RAS refresh path
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_GRANT_DELAY,  // Stands in for the 25 ns grant delay
        ST_ROW,          // RAS up, row address latched
        ST_BUS_WAIT,     // Bus write paused for data
        ST_COL,          // CAS up, lanes enabled
        ST_COL_HOLD,     // Read data valid
        ST_PRECHARGE,    // Strobes down
        ST_REF_CAS,      // CAS first
        ST_REF_RAS,      // Then RAS
        ST_REF_HOLD
    } seq_state_t;

endpackage

`default_nettype wire

/* rtl/grant_arbiter.sv */
// Refresh interval counter, fixed-priority request selection and registered grant
`timescale 1ns/1ps
`default_nettype none

module grant_arbiter (
    input  wire                 CK,
    input  wire                 arst_n,
    input  wire                 cpu_req,          // Held until cpu_done
    input  wire                 bus_req,          // Held until bus_done
    input  wire                 seq_idle,         // Sequencer can accept a grant
    input  wire                 cycle_end,        // Last cycle of an access or refresh
    output logic                gnt,              // One-cycle pulse
    output ram_pkg::src_t       gnt_src,          // Source of the latest grant
    output logic                refresh_pending   // Sticky until its refresh retires
);

    logic [ram_pkg::REF_CNT_W-1:0] ref_cnt;
    logic                          ref_tick;   // Interval elapsed
    logic                          busy;       // Grant out, cycle not retired yet
    logic                          can_grant;
    ram_pkg::src_t                 next_src;

    assign ref_tick = (ref_cnt == ram_pkg::REF_LAST);

    // One grant per idle window, busy keeps a held request from a second grant
    assign can_grant = seq_idle && !busy && (refresh_pending || cpu_req || bus_req);

    // Refresh first, then CPU, bus last
    always_comb begin
        if (refresh_pending) begin
            next_src = ram_pkg::SRC_REFRESH;
        end else if (cpu_req) begin
            next_src = ram_pkg::SRC_CPU;
        end else begin
            next_src = ram_pkg::SRC_BUS;
        end
    end

    // Free-running interval counter
    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            ref_cnt <= '0;
        end else if (ref_tick) begin
            ref_cnt <= '0;
        end else begin
            ref_cnt <= ref_cnt + 1'b1;
        end
    end

    // A new tick wins over a retiring refresh, the next one is already due
    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            refresh_pending <= 1'b0;
        end else if (ref_tick) begin
            refresh_pending <= 1'b1;
        end else if (cycle_end && gnt_src == ram_pkg::SRC_REFRESH) begin
            refresh_pending <= 1'b0;
        end
    end

    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            gnt     <= 1'b0;
            gnt_src <= ram_pkg::SRC_CPU;
            busy    <= 1'b0;
        end else begin
            gnt <= can_grant;  // Request seen, grant one cycle later
            if (can_grant) begin
                gnt_src <= next_src;
                busy    <= 1'b1;
            end else if (cycle_end) begin
                busy <= 1'b0;  // Requester drops its level after done
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/ram_sequencer.sv */
// RAS/CAS/byte-lane state machine with bus data wait and timeout
`timescale 1ns/1ps
`default_nettype none

module ram_sequencer (
    input  wire                         CK,
    input  wire                         arst_n,
    input  wire                         gnt,
    input  ram_pkg::src_t               gnt_src,
    input  wire                         cpu_we,
    input  wire  [ram_pkg::ADDR_W-1:0]  cpu_addr,
    input  wire  [1:0]                  cpu_be,
    input  wire  [ram_pkg::DATA_W-1:0]  cpu_wdata,
    input  wire                         bus_we,
    input  wire  [ram_pkg::ADDR_W-1:0]  bus_addr,
    input  wire  [1:0]                  bus_be,
    input  wire  [ram_pkg::DATA_W-1:0]  bus_wdata,
    input  wire                         bus_dap,      // Bus write data present
    output logic                        seq_idle,
    output logic                        cycle_end,
    output logic                        ras,
    output logic                        cas,
    output logic                        loen_n,
    output logic                        hien_n,
    output logic                        we,
    output logic [ram_pkg::ROW_W-1:0]   row_addr,
    output logic [ram_pkg::COL_W-1:0]   col_addr,
    output logic [ram_pkg::DATA_W-1:0]  wdata,
    output logic                        cpu_done,
    output logic                        bus_done,
    output logic                        bus_timeout
);

    ram_pkg::seq_state_t                state, state_next;
    ram_pkg::src_t                      cmd_src;
    logic                               cmd_we;
    logic [ram_pkg::ADDR_W-1:0]         cmd_addr;
    logic [1:0]                         cmd_be;
    logic [ram_pkg::DATA_W-1:0]         cmd_wdata;
    logic                               dap_seen;    // Sticky since grant
    logic                               dap_now;
    logic [ram_pkg::WAIT_CNT_W-1:0]     wait_cnt;
    logic                               wait_expired;
    logic                               timed_out;
    logic                               lanes_off;   // Aborted bus write

    assign dap_now      = dap_seen || bus_dap;
    assign wait_expired = (state == ram_pkg::ST_BUS_WAIT) && !dap_now
                          && (wait_cnt == ram_pkg::WAIT_LAST);
    assign lanes_off    = wait_expired;

    assign seq_idle  = (state == ram_pkg::ST_IDLE);
    assign cycle_end = (state == ram_pkg::ST_PRECHARGE) || (state == ram_pkg::ST_REF_HOLD);

    assign we       = cmd_we;
    assign row_addr = cmd_addr[ram_pkg::ADDR_W-1 -: ram_pkg::ROW_W];
    assign col_addr = cmd_addr[ram_pkg::COL_W-1:0];
    assign wdata    = cmd_wdata;

    always_comb begin
        state_next = state;
        case (state)
            ram_pkg::ST_IDLE: begin
                if (gnt) begin
                    // Refresh skips the grant delay
                    state_next = (gnt_src == ram_pkg::SRC_REFRESH) ? ram_pkg::ST_REF_CAS
                                                                   : ram_pkg::ST_GRANT_DELAY;
                end
            end
            ram_pkg::ST_GRANT_DELAY: state_next = ram_pkg::ST_ROW;
            ram_pkg::ST_ROW: begin
                // Only bus writes wait, CPU writes have data with the request
                state_next = (cmd_src == ram_pkg::SRC_BUS && cmd_we) ? ram_pkg::ST_BUS_WAIT
                                                                     : ram_pkg::ST_COL;
            end
            ram_pkg::ST_BUS_WAIT: begin
                if (dap_now || wait_expired) begin
                    state_next = ram_pkg::ST_COL;
                end
            end
            ram_pkg::ST_COL:       state_next = ram_pkg::ST_COL_HOLD;
            ram_pkg::ST_COL_HOLD:  state_next = ram_pkg::ST_PRECHARGE;
            ram_pkg::ST_PRECHARGE: state_next = ram_pkg::ST_IDLE;
            ram_pkg::ST_REF_CAS:   state_next = ram_pkg::ST_REF_RAS;
            ram_pkg::ST_REF_RAS:   state_next = ram_pkg::ST_REF_HOLD;
            ram_pkg::ST_REF_HOLD:  state_next = ram_pkg::ST_IDLE;
            default:               state_next = ram_pkg::ST_IDLE;
        endcase
    end

    // Command latch, payload only
    always_ff @(posedge CK) begin
        if (seq_idle && gnt) begin
            if (gnt_src == ram_pkg::SRC_BUS) begin
                cmd_addr  <= bus_addr;
                cmd_be    <= bus_be;
                cmd_wdata <= bus_wdata;
            end else begin
                cmd_addr  <= cpu_addr;   // Don't care on refresh
                cmd_be    <= cpu_be;
                cmd_wdata <= cpu_wdata;
            end
        end else if (cmd_src == ram_pkg::SRC_BUS && bus_dap && !dap_seen) begin
            cmd_wdata <= bus_wdata;  // Bus data arrives with its first dap
        end
    end

    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ram_pkg::ST_IDLE;
            cmd_src   <= ram_pkg::SRC_CPU;
            cmd_we    <= 1'b0;
            dap_seen  <= 1'b0;
            wait_cnt  <= '0;
            timed_out <= 1'b0;
        end else begin
            state <= state_next;
            if (seq_idle && gnt) begin
                cmd_src   <= gnt_src;
                cmd_we    <= (gnt_src == ram_pkg::SRC_CPU) ? cpu_we
                           : (gnt_src == ram_pkg::SRC_BUS) ? bus_we : 1'b0;
                dap_seen  <= 1'b0;
                timed_out <= 1'b0;
            end else begin
                if (bus_dap) dap_seen <= 1'b1;
                if (wait_expired) timed_out <= 1'b1;
            end
            // Counts cycles spent in the wait state
            wait_cnt <= (state == ram_pkg::ST_BUS_WAIT) ? wait_cnt + 1'b1 : '0;
        end
    end

    // Registered strobes decoded from the next state, like the PAL outputs
    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            ras         <= 1'b0;
            cas         <= 1'b0;
            loen_n      <= 1'b1;
            hien_n      <= 1'b1;
            cpu_done    <= 1'b0;
            bus_done    <= 1'b0;
            bus_timeout <= 1'b0;
        end else begin
            ras <= (state_next inside {ram_pkg::ST_ROW, ram_pkg::ST_BUS_WAIT, ram_pkg::ST_COL,
                                       ram_pkg::ST_COL_HOLD, ram_pkg::ST_REF_RAS});
            cas <= (state_next inside {ram_pkg::ST_COL, ram_pkg::ST_COL_HOLD,
                                       ram_pkg::ST_REF_CAS, ram_pkg::ST_REF_RAS});
            // Reads open both lanes, writes follow byte enables
            loen_n <= !(state_next == ram_pkg::ST_COL && !lanes_off && (!cmd_we || cmd_be[0]));
            hien_n <= !(state_next == ram_pkg::ST_COL && !lanes_off && (!cmd_we || cmd_be[1]));
            cpu_done    <= (state == ram_pkg::ST_COL_HOLD) && (cmd_src == ram_pkg::SRC_CPU);
            bus_done    <= (state == ram_pkg::ST_COL_HOLD) && (cmd_src == ram_pkg::SRC_BUS);
            bus_timeout <= (state == ram_pkg::ST_COL_HOLD) && (cmd_src == ram_pkg::SRC_BUS)
                           && timed_out;
        end
    end

endmodule

`default_nettype wire

/* rtl/dram_bank.sv */
// Behavioral DRAM bank with RAS row latch, CAS column access and byte-lane writes
`timescale 1ns/1ps
`default_nettype none

module dram_bank (
    input  wire                         CK,
    input  wire                         arst_n,
    input  wire                         ras,        // Active high
    input  wire                         cas,        // Active high
    input  wire                         loen_n,     // Low lane enable
    input  wire                         hien_n,     // High lane enable
    input  wire                         we,
    input  wire  [ram_pkg::ROW_W-1:0]   row_addr,
    input  wire  [ram_pkg::COL_W-1:0]   col_addr,
    input  wire  [ram_pkg::DATA_W-1:0]  wdata,
    output logic [ram_pkg::DATA_W-1:0]  rdata
);

    localparam int DEPTH = 2 ** ram_pkg::ADDR_W;
    localparam int LW    = ram_pkg::LANE_W;

    logic [ram_pkg::DATA_W-1:0] mem [DEPTH];
    logic                       ras_q;
    logic                       cas_q;
    logic                       ras_rise;
    logic                       cas_rise;
    logic                       cbr;        // CAS went up first, refresh cycle
    logic                       col_access;
    logic [ram_pkg::ROW_W-1:0]  row_q;
    logic [ram_pkg::ADDR_W-1:0] word_addr;

    assign ras_rise   = ras && !ras_q;
    assign cas_rise   = cas && !cas_q;
    assign col_access = cas_rise && ras;   // Normal access, row already open
    assign word_addr  = {row_q, col_addr};

    // Edge detect and refresh mode flag
    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            ras_q <= 1'b0;
            cas_q <= 1'b0;
            cbr   <= 1'b0;
        end else begin
            ras_q <= ras;
            cas_q <= cas;
            if (cas_rise && !ras) begin
                cbr <= 1'b1;             // CAS before RAS
            end else if (!cas) begin
                cbr <= 1'b0;
            end
        end
    end

    // Row address taken on RAS, ignored in refresh
    always_ff @(posedge CK) begin
        if (ras_rise && !cbr) begin
            row_q <= row_addr;
        end
    end

    // Column strobe commits a write or fetches the word
    always_ff @(posedge CK) begin
        if (col_access) begin
            if (we) begin
                if (!loen_n) mem[word_addr][LW-1:0] <= wdata[LW-1:0];
                if (!hien_n) mem[word_addr][2*LW-1:LW] <= wdata[2*LW-1:LW];
            end else begin
                if (!loen_n) rdata[LW-1:0] <= mem[word_addr][LW-1:0];
                if (!hien_n) rdata[2*LW-1:LW] <= mem[word_addr][2*LW-1:LW];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/ram_subsystem.sv */
// Top level wiring of grant arbiter, RAM sequencer and DRAM bank
`timescale 1ns/1ps
`default_nettype none

module ram_subsystem (
    input  wire                         CK,
    input  wire                         arst_n,
    // Processor port
    input  wire                         cpu_req,
    input  wire                         cpu_we,
    input  wire  [ram_pkg::ADDR_W-1:0]  cpu_addr,
    input  wire  [ram_pkg::DATA_W-1:0]  cpu_wdata,
    input  wire  [1:0]                  cpu_be,
    output wire                         cpu_done,
    // Bus port
    input  wire                         bus_req,
    input  wire                         bus_we,
    input  wire  [ram_pkg::ADDR_W-1:0]  bus_addr,
    input  wire  [ram_pkg::DATA_W-1:0]  bus_wdata,
    input  wire  [1:0]                  bus_be,
    input  wire                         bus_dap,
    output wire                         bus_done,
    output wire                         bus_timeout,
    // Shared read data, valid with either done
    output wire  [ram_pkg::DATA_W-1:0]  rdata,
    // RAM strobes
    output wire                         ras,
    output wire                         cas,
    output wire                         loen_n,
    output wire                         hien_n
);

    wire                         gnt;
    ram_pkg::src_t               gnt_src;
    wire                         seq_idle;
    wire                         cycle_end;
    wire                         we;
    wire [ram_pkg::ROW_W-1:0]    row_addr;
    wire [ram_pkg::COL_W-1:0]    col_addr;
    wire [ram_pkg::DATA_W-1:0]   wdata;

    grant_arbiter u_arbiter (
        .CK              (CK),
        .arst_n          (arst_n),
        .cpu_req         (cpu_req),
        .bus_req         (bus_req),
        .seq_idle        (seq_idle),
        .cycle_end       (cycle_end),
        .gnt             (gnt),
        .gnt_src         (gnt_src),
        .refresh_pending ()              // Observed through hierarchy in simulation
    );

    ram_sequencer u_sequencer (
        .CK          (CK),
        .arst_n      (arst_n),
        .gnt         (gnt),
        .gnt_src     (gnt_src),
        .cpu_we      (cpu_we),
        .cpu_addr    (cpu_addr),
        .cpu_be      (cpu_be),
        .cpu_wdata   (cpu_wdata),
        .bus_we      (bus_we),
        .bus_addr    (bus_addr),
        .bus_be      (bus_be),
        .bus_wdata   (bus_wdata),
        .bus_dap     (bus_dap),
        .seq_idle    (seq_idle),
        .cycle_end   (cycle_end),
        .ras         (ras),
        .cas         (cas),
        .loen_n      (loen_n),
        .hien_n      (hien_n),
        .we          (we),
        .row_addr    (row_addr),
        .col_addr    (col_addr),
        .wdata       (wdata),
        .cpu_done    (cpu_done),
        .bus_done    (bus_done),
        .bus_timeout (bus_timeout)
    );

    dram_bank u_bank (
        .CK       (CK),
        .arst_n   (arst_n),
        .ras      (ras),
        .cas      (cas),
        .loen_n   (loen_n),
        .hien_n   (hien_n),
        .we       (we),
        .row_addr (row_addr),
        .col_addr (col_addr),
        .wdata    (wdata),
        .rdata    (rdata)
    );

endmodule

`default_nettype wire

/* verification/tb_ram_subsystem.sv */
// Testbench with clock, reset, random CPU and bus traffic, reference memory, refresh monitor, timeout
`timescale 1ns/1ps
`default_nettype none

module tb_ram_subsystem;

    localparam int AW          = ram_pkg::ADDR_W;
    localparam int DW          = ram_pkg::DATA_W;
    localparam int LW          = ram_pkg::LANE_W;
    localparam int DEPTH       = 2 ** AW;
    localparam int NUM_CPU     = 160;
    localparam int NUM_BUS     = 40;   // Bus writes with data, each read back
    localparam int NUM_ABORT   = 20;   // Known word, bus write without data, read back
    localparam int NUM_PAIRS   = 50;   // CPU and bus raised in the same cycle
    localparam int NUM_TRANS   = NUM_CPU + 2 * NUM_BUS + 3 * NUM_ABORT + 2 * NUM_PAIRS;
    localparam int CYCLE_LIMIT = NUM_TRANS * 20 + 500;
    localparam int REFRESH_GAP = ram_pkg::REFRESH_INTERVAL + 20;

    logic          CK, arst_n;
    logic          cpu_req, cpu_we, bus_req, bus_we, bus_dap;
    logic [AW-1:0] cpu_addr, bus_addr;
    logic [DW-1:0] cpu_wdata, bus_wdata;
    logic [1:0]    cpu_be, bus_be;
    wire           cpu_done, bus_done, bus_timeout;
    wire           ras, cas, loen_n, hien_n;
    wire  [DW-1:0] rdata;

    logic [DW-1:0] model_mem [DEPTH];    // Reference words
    logic [1:0]    model_known [DEPTH];  // Lanes written so far

    int   cycle_cnt = 0;
    int   since_refresh = 0;
    int   refresh_cnt = 0;
    int   cpu_done_cnt = 0;
    int   bus_done_cnt = 0;
    int   cpu_issued = 0;
    int   bus_issued = 0;
    logic cas_prev = 1'b0;

    ram_subsystem i_dut (.*);

    always #50 CK = ~CK;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("FAIL %s expected 0x%h got 0x%h", name, expected, actual));
        end
    endtask

    // Inputs change 5 ns after the edge, outputs settled by then
    task automatic next_cycle();
        @(posedge CK);
        #5;
    endtask

    task automatic update_model(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                                input logic [1:0] be);
        if (be[0]) begin
            model_mem[addr][LW-1:0] = data[LW-1:0];
            model_known[addr][0]    = 1'b1;
        end
        if (be[1]) begin
            model_mem[addr][DW-1:LW] = data[DW-1:LW];
            model_known[addr][1]     = 1'b1;
        end
    endtask

    // Lanes never written are masked out
    task automatic compare_read(input logic [AW-1:0] addr);
        logic [DW-1:0] mask;
        mask = {{LW{model_known[addr][1]}}, {LW{model_known[addr][0]}}};
        check("rdata", 32'(model_mem[addr] & mask), 32'(rdata & mask));
    endtask

    task automatic finish_cpu(input logic wr, input logic [AW-1:0] addr,
                              input logic [DW-1:0] data, input logic [1:0] be);
        if (wr) update_model(addr, data, be);
        else compare_read(addr);
    endtask

    task automatic set_cpu(input logic wr, input logic [AW-1:0] addr,
                           input logic [DW-1:0] data, input logic [1:0] be);
        cpu_we    = wr;
        cpu_addr  = addr;
        cpu_wdata = data;
        cpu_be    = be;
        cpu_req   = 1'b1;  // Held until done
        cpu_issued++;
    endtask

    task automatic cpu_access(input logic wr, input logic [AW-1:0] addr,
                              input logic [DW-1:0] data, input logic [1:0] be);
        set_cpu(wr, addr, data, be);
        do next_cycle(); while (!cpu_done);
        cpu_req = 1'b0;
        finish_cpu(wr, addr, data, be);
    endtask

    // Negative dap_delay leaves the write without data
    task automatic bus_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                             input logic [1:0] be, input int dap_delay);
        int since_row;
        bit row_seen;
        since_row = 0;
        row_seen  = 1'b0;
        bus_we    = 1'b1;
        bus_addr  = addr;
        bus_wdata = ~data;  // Stale until bus_dap
        bus_be    = be;
        bus_req   = 1'b1;
        bus_issued++;
        do begin
            next_cycle();
            bus_dap = 1'b0;
            if (ras && !cas) row_seen = 1'b1;  // Access row, refresh raises cas first
            if (row_seen) begin
                if (since_row == dap_delay) begin
                    bus_dap   = 1'b1;
                    bus_wdata = data;  // Data valid with its strobe
                end
                since_row++;
            end
        end while (!bus_done);
        bus_req = 1'b0;
        bus_dap = 1'b0;
        check("bus_timeout", 32'(dap_delay < 0), 32'(bus_timeout));
        if (dap_delay >= 0) update_model(addr, data, be);
    endtask

    // CPU access and bus read raised together, CPU goes first
    task automatic run_pair(input logic wr, input logic [AW-1:0] c_addr,
                            input logic [DW-1:0] data, input logic [1:0] be,
                            input logic [AW-1:0] b_addr);
        bit cpu_fin;
        bit bus_fin;
        cpu_fin  = 1'b0;
        bus_fin  = 1'b0;
        bus_we   = 1'b0;
        bus_addr = b_addr;
        bus_be   = 2'b11;
        bus_req  = 1'b1;
        bus_issued++;
        set_cpu(wr, c_addr, data, be);
        while (!(cpu_fin && bus_fin)) begin
            next_cycle();
            if (cpu_done) begin
                cpu_req = 1'b0;
                cpu_fin = 1'b1;
                finish_cpu(wr, c_addr, data, be);
            end
            if (bus_done) begin
                check("cpu_done before bus_done", 32'd1, 32'(cpu_fin));
                bus_req = 1'b0;
                bus_fin = 1'b1;
                compare_read(b_addr);
            end
        end
    endtask

    // Four columns per row keeps reads landing on written words
    function automatic logic [AW-1:0] pick_addr();
        logic [31:0] r;
        r = $urandom;
        return {r[ram_pkg::ROW_W+7:8], {(ram_pkg::COL_W-2){1'b0}}, r[1:0]};
    endfunction

    // Done counters, refresh spacing and the run limit
    always @(negedge CK) begin
        if (arst_n) begin
            cycle_cnt++;
            if (cpu_done) cpu_done_cnt++;
            if (bus_done) bus_done_cnt++;
            if (cas && !cas_prev && !ras) begin
                refresh_cnt++;  // CAS before RAS
                since_refresh = 0;
            end else begin
                since_refresh++;
            end
            cas_prev = cas;
            if (bus_timeout && !bus_done) fail_run("bus_timeout pulsed without bus_done");
            if (since_refresh > REFRESH_GAP) fail_run("refresh did not come in time");
            if (cycle_cnt > CYCLE_LIMIT) fail_run("run hung, cycle limit reached");
        end
    end

    initial begin
        logic [31:0]   r;
        logic [31:0]   d;
        logic [AW-1:0] addr;
        CK        = 1'b0;
        arst_n    = 1'b0;
        cpu_req   = 1'b0;
        bus_req   = 1'b0;
        bus_dap   = 1'b0;
        bus_we    = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        bus_be    = '0;
        set_cpu(1'b0, '0, '0, '0);
        cpu_req    = 1'b0;
        cpu_issued = 0;
        for (int i = 0; i < DEPTH; i++) model_known[i] = 2'b00;
        void'($urandom(93));
        repeat (3) @(posedge CK);
        #5;
        arst_n = 1'b1;
        check("ras", 32'd0, 32'(ras));
        check("cas", 32'd0, 32'(cas));
        check("loen_n", 32'd1, 32'(loen_n));
        check("hien_n", 32'd1, 32'(hien_n));
        check("cpu_done", 32'd0, 32'(cpu_done));
        check("bus_done", 32'd0, 32'(bus_done));
        check("bus_timeout", 32'd0, 32'(bus_timeout));
        check("gnt", 32'd0, 32'(i_dut.u_arbiter.gnt));
        check("refresh_pending", 32'd0, 32'(i_dut.u_arbiter.refresh_pending));
        repeat (8) next_cycle();
        check("cpu_done count", 32'd0, cpu_done_cnt);
        check("bus_done count", 32'd0, bus_done_cnt);

        for (int i = 0; i < NUM_CPU; i++) begin
            r = $urandom;
            d = $urandom;
            cpu_access(r[0], pick_addr(), d[DW-1:0], r[2:1]);
            repeat (int'(r[4:3])) next_cycle();  // Random gap
        end
        for (int i = 0; i < NUM_BUS; i++) begin
            r    = $urandom;
            d    = $urandom;
            addr = pick_addr();
            bus_write(addr, d[DW-1:0], r[1:0], int'(r[7:4]) % ram_pkg::BUS_WAIT_LIMIT);
            cpu_access(1'b0, addr, '0, 2'b11);
        end
        for (int i = 0; i < NUM_ABORT; i++) begin
            r    = $urandom;
            d    = $urandom;
            addr = pick_addr();
            cpu_access(1'b1, addr, r[DW-1:0], 2'b11);  // Known word first
            bus_write(addr, d[DW-1:0], 2'b11, -1);
            cpu_access(1'b0, addr, '0, 2'b11);  // Old word expected
        end
        for (int i = 0; i < NUM_PAIRS; i++) begin
            r = $urandom;
            d = $urandom;
            run_pair(r[0], pick_addr(), d[DW-1:0], r[2:1], pick_addr());
        end

        repeat (20) next_cycle();
        check("cpu_done count", cpu_issued, cpu_done_cnt);
        check("bus_done count", bus_issued, bus_done_cnt);
        if (refresh_cnt == 0) begin
            fail_run("no refresh cycle was seen");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
rtl/ram_pkg.sv
rtl/grant_arbiter.sv
rtl/ram_sequencer.sv
rtl/dram_bank.sv
rtl/ram_subsystem.sv
verification/tb_ram_subsystem.sv

/* Makefile */
# Verilator build and run of the RAM subsystem testbench
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := tb_ram_subsystem
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

# The log decides the result, the simulator status is not used
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^all tests passed$$" $(LOG) && echo "Result PASS" || { echo "Result FAIL"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
